// ==== hdl/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// datapath widths
`define LSU_ADDR_W 32
`define LSU_WORD_W 32
`define LSU_BEAT_W 64
`define LSU_STRB_W 8

// bus tags and register index
`define LSU_ID_W 4
`define LSU_REG_W 5

// every transfer moves a 4-byte word
`define LSU_SIZE_WORD 3'b010

// okay response code on R and B
`define LSU_RESP_OKAY 2'b00

`endif

// ==== hdl/lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

	typedef logic [`LSU_ADDR_W-1:0] addr_t;
	typedef logic [`LSU_WORD_W-1:0] word_t;
	typedef logic [`LSU_BEAT_W-1:0] beat_t;
	typedef logic [`LSU_STRB_W-1:0] strb_t;
	typedef logic [`LSU_ID_W-1:0]   axi_id_t;
	typedef logic [`LSU_REG_W-1:0]  reg_idx_t;

	typedef enum logic [3:0] {
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW
	} mem_op_e;

	typedef enum logic [2:0] {
		RD_IDLE, RD_ADDR, RD_DATA, RD_DONE, RD_AGAIN
	} read_state_e;

	typedef enum logic [2:0] {
		WR_IDLE, WR_ADDR, WR_DATA, WR_RESP, WR_DONE, WR_AGAIN
	} write_state_e;

	// request as handed over by the execute stage
	typedef struct packed {
		mem_op_e  op;
		addr_t    addr;
		word_t    store_data;
		reg_idx_t rd;
	} mem_req_t;

	// one or two passes of an access
	typedef struct packed {
		addr_t first_addr;
		addr_t second_addr;
		strb_t first_strb;
		strb_t second_strb;
		logic  need_second;
		beat_t wdata;
	} lane_plan_t;

	// shared by AR and AW
	typedef struct packed {
		logic       valid;
		addr_t      addr;
		axi_id_t    id;
		logic [2:0] size;
	} ar_chan_t;

	typedef struct packed {
		logic  valid;
		beat_t data;
		strb_t strb;
		logic  last;
	} w_chan_t;

	typedef struct packed {
		logic       valid;
		beat_t      data;
		logic [1:0] resp;
		logic       last;
		axi_id_t    id;
	} r_chan_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] resp;
		axi_id_t    id;
	} b_chan_t;

endpackage

// ==== hdl/lsu_lane_map.sv ====
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_lane_map import lsu_pkg::*; (
	input  mem_req_t   req,
	output lane_plan_t plan
);

	logic [2:0]   offset;
	logic [3:0]   size_mask;
	logic [15:0]  spread;
	logic [3:0]   low_half;
	logic [3:0]   high_half;
	logic [3:0]   spill;
	addr_t        word_base;
	beat_t        wdata_zext;
	logic [127:0] wdata_dbl;

	// byte lane of the access inside the 8-byte beat
	assign offset = req.addr[2:0];

	// --------------------------------------------------
	// access size
	// --------------------------------------------------

	always_comb begin
		case (req.op)
			OP_LW, OP_SW: begin
				size_mask = 4'b1111;
			end
			OP_LH, OP_LHU, OP_SH: begin
				size_mask = 4'b0011;
			end
			default: begin
				size_mask = 4'b0001;
			end
		endcase
	end

	// touched bytes placed at the lane offset, may run past the word
	assign spread = {12'b0, size_mask} << offset;

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------

	// bytes that fall inside the addressed word
	assign low_half  = spread[3:0];
	assign high_half = spread[7:4];

	// bytes that run over into the next word
	assign spill = offset[2] ? spread[11:8] : spread[7:4];

	always_comb begin
		if (offset[2]) begin
			plan.first_strb = {high_half, 4'b0000};
		end else begin
			plan.first_strb = {4'b0000, low_half};
		end
	end

	// next word sits in the upper half of this beat or the lower half of the next
	always_comb begin
		if (offset[2]) begin
			plan.second_strb = {4'b0000, spill};
		end else begin
			plan.second_strb = {spill, 4'b0000};
		end
	end

	assign plan.need_second = |spill;

	// --------------------------------------------------
	// addresses
	// --------------------------------------------------

	assign word_base = {req.addr[`LSU_ADDR_W-1:2], 2'b00};

	assign plan.first_addr  = word_base;
	assign plan.second_addr = word_base + addr_t'(4);

	// --------------------------------------------------
	// write lanes
	// --------------------------------------------------

	assign wdata_zext = {{(`LSU_BEAT_W-`LSU_WORD_W){1'b0}}, req.store_data};

	// rotate left by whole bytes, spilled bytes wrap to the low lanes
	assign wdata_dbl  = {wdata_zext, wdata_zext} << {offset, 3'b000};
	assign plan.wdata = wdata_dbl[127:64];

endmodule

// ==== hdl/lsu_read_engine.sv ====
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_read_engine import lsu_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  lane_plan_t plan,
	input  logic       ar_ready,
	input  r_chan_t    r,
	output ar_chan_t   ar,
	output logic       r_ready,
	output logic       done,
	output beat_t      first_beat,
	output beat_t      last_beat
);

	read_state_e state;
	logic        second;
	logic        ar_valid;
	addr_t       ar_addr;
	axi_id_t     next_id;
	axi_id_t     sent_id;
	logic        ar_fire;
	logic        r_match;

	assign ar_fire = ar_valid && ar_ready;

	// stray ids are accepted and dropped
	assign r_match = r_ready && r.valid && (r.id == sent_id);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= RD_IDLE;
			second   <= 1'b0;
			ar_valid <= 1'b0;
			r_ready  <= 1'b0;
			next_id  <= '0;
			sent_id  <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (start) begin
						second   <= 1'b0;
						ar_valid <= 1'b1;
						state    <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (ar_fire) begin
						ar_valid <= 1'b0;
						r_ready  <= 1'b1;
						sent_id  <= next_id;
						next_id  <= next_id + axi_id_t'(1);
						state    <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (r_match) begin
						r_ready <= 1'b0;
						state   <= (plan.need_second && !second) ? RD_AGAIN : RD_DONE;
					end
				end
				RD_AGAIN: begin
					second   <= 1'b1;
					ar_valid <= 1'b1;
					state    <= RD_ADDR;
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

	// address follows the pass, held while ar_valid waits
	always_ff @(posedge clock) begin
		if (state == RD_IDLE && start) begin
			ar_addr <= plan.first_addr;
		end else if (state == RD_AGAIN) begin
			ar_addr <= plan.second_addr;
		end
	end

	// beat capture
	always_ff @(posedge clock) begin
		if (r_match) begin
			last_beat <= r.data;
			if (!second) begin
				first_beat <= r.data;
			end
		end
	end

	assign ar = '{valid: ar_valid, addr: ar_addr, id: next_id, size: `LSU_SIZE_WORD};

	assign done = (state == RD_DONE);

endmodule

// ==== hdl/lsu_write_engine.sv ====
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_write_engine import lsu_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  lane_plan_t plan,
	input  logic       aw_ready,
	input  logic       w_ready,
	input  b_chan_t    b,
	output ar_chan_t   aw,
	output w_chan_t    w,
	output logic       b_ready,
	output logic       done
);

	write_state_e state;
	logic         second;
	logic         aw_valid;
	logic         w_valid;
	addr_t        aw_addr;
	beat_t        w_data;
	strb_t        w_strb;
	axi_id_t      next_id;
	axi_id_t      sent_id;
	logic         aw_fire;
	logic         w_fire;
	logic         b_match;

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire  = w_valid && w_ready;
	assign b_match = b_ready && b.valid && (b.id == sent_id);

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= WR_IDLE;
			second   <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
			b_ready  <= 1'b0;
			next_id  <= '0;
			sent_id  <= '0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (start) begin
						second   <= 1'b0;
						aw_valid <= 1'b1;
						state    <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (aw_fire) begin
						aw_valid <= 1'b0;
						w_valid  <= 1'b1;
						sent_id  <= next_id;
						next_id  <= next_id + axi_id_t'(1);
						state    <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_fire) begin
						w_valid <= 1'b0;
						b_ready <= 1'b1;
						state   <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (b_match) begin
						b_ready <= 1'b0;
						state   <= (plan.need_second && !second) ? WR_AGAIN : WR_DONE;
					end
				end
				WR_AGAIN: begin
					second   <= 1'b1;
					aw_valid <= 1'b1;
					state    <= WR_ADDR;
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == WR_IDLE && start) begin
			aw_addr <= plan.first_addr;
		end else if (state == WR_AGAIN) begin
			aw_addr <= plan.second_addr;
		end
	end

	// same rotated data on both passes, only the strobe differs
	always_ff @(posedge clock) begin
		if (aw_fire) begin
			w_data <= plan.wdata;
			w_strb <= second ? plan.second_strb : plan.first_strb;
		end
	end

	assign aw = '{valid: aw_valid, addr: aw_addr, id: next_id, size: `LSU_SIZE_WORD};

	// single beat, so last goes with valid
	assign w = '{valid: w_valid, data: w_data, strb: w_strb, last: w_valid};

	assign done = (state == WR_DONE);

endmodule

// ==== hdl/lsu_load_merge.sv ====
`timescale 1ns/100ps

module lsu_load_merge import lsu_pkg::*; (
	input  lane_plan_t plan,
	input  mem_op_e    op,
	input  beat_t      first_beat,
	input  beat_t      last_beat,
	output word_t      data
);

	logic [3:0]  group_strb;
	logic [1:0]  lane;
	word_t       gathered;
	logic [63:0] rot_dbl;
	word_t       aligned;

	assign group_strb = plan.first_strb[3:0] | plan.first_strb[7:4];

	// first strobe starts at the byte offset, so its lowest bit gives addr[1:0]
	always_comb begin
		lane = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (group_strb[i]) begin
				lane = i[1:0];
			end
		end
	end

	// --------------------------------------------------
	// byte gather
	// --------------------------------------------------

	// each word lane takes its byte from whichever beat enabled it
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			gathered[8*k +: 8] =
				({8{plan.first_strb[k]}}    & first_beat[8*k +: 8]) |
				({8{plan.first_strb[k+4]}}  & first_beat[8*(k+4) +: 8]) |
				({8{plan.second_strb[k]}}   & last_beat[8*k +: 8]) |
				({8{plan.second_strb[k+4]}} & last_beat[8*(k+4) +: 8]);
		end
	end

	// rotate right so the addressed byte lands in bits 7:0
	assign rot_dbl = {gathered, gathered} >> {lane, 3'b000};
	assign aligned = rot_dbl[31:0];

	// --------------------------------------------------
	// extension
	// --------------------------------------------------

	always_comb begin
		case (op)
			OP_LB: begin
				data = {{24{aligned[7]}}, aligned[7:0]};
			end
			OP_LBU: begin
				data = {24'b0, aligned[7:0]};
			end
			OP_LH: begin
				data = {{16{aligned[15]}}, aligned[15:0]};
			end
			OP_LHU: begin
				data = {16'b0, aligned[15:0]};
			end
			default: begin
				data = aligned;
			end
		endcase
	end

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/100ps

module lsu import lsu_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     req_valid,
	input  mem_req_t req,
	output logic     req_allowin,
	output ar_chan_t ar,
	input  logic     ar_ready,
	input  r_chan_t  r,
	output logic     r_ready,
	output ar_chan_t aw,
	input  logic     aw_ready,
	output w_chan_t  w,
	input  logic     w_ready,
	input  b_chan_t  b,
	output logic     b_ready,
	output logic     rf_wen,
	output reg_idx_t rf_waddr,
	output word_t    rf_wdata
);

	mem_req_t   req_q;
	logic       stage_valid;
	logic       start_pending;
	logic       accept;
	logic       is_load;
	lane_plan_t plan;
	logic       rd_done;
	logic       wr_done;
	beat_t      first_beat;
	beat_t      last_beat;
	word_t      load_data;

	// --------------------------------------------------
	// request stage
	// --------------------------------------------------

	assign accept      = req_valid && req_allowin;
	assign req_allowin = !stage_valid || rd_done || wr_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid   <= 1'b0;
			start_pending <= 1'b0;
		end else begin
			if (req_allowin) begin
				stage_valid <= req_valid;
			end
			start_pending <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= req;
		end
	end

	assign is_load = req_q.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

	// --------------------------------------------------
	// engines
	// --------------------------------------------------

	lsu_lane_map u_lane_map (
		.req  (req_q),
		.plan (plan)
	);

	lsu_read_engine u_read_engine (
		.clock      (clock),
		.reset      (reset),
		.start      (start_pending && is_load),
		.plan       (plan),
		.ar_ready   (ar_ready),
		.r          (r),
		.ar         (ar),
		.r_ready    (r_ready),
		.done       (rd_done),
		.first_beat (first_beat),
		.last_beat  (last_beat)
	);

	lsu_write_engine u_write_engine (
		.clock    (clock),
		.reset    (reset),
		.start    (start_pending && !is_load),
		.plan     (plan),
		.aw_ready (aw_ready),
		.w_ready  (w_ready),
		.b        (b),
		.aw       (aw),
		.w        (w),
		.b_ready  (b_ready),
		.done     (wr_done)
	);

	lsu_load_merge u_load_merge (
		.plan       (plan),
		.op         (req_q.op),
		.first_beat (first_beat),
		.last_beat  (last_beat),
		.data       (load_data)
	);

	// writeback on load completion only
	assign rf_wen   = rd_done;
	assign rf_waddr = req_q.rd;
	assign rf_wdata = load_data;

endmodule

// ==== verification/lsu_props.sv ====
`timescale 1ns/100ps

module lsu_props import lsu_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     req_allowin,
	input ar_chan_t ar,
	input logic     ar_ready,
	input ar_chan_t aw,
	input logic     aw_ready,
	input w_chan_t  w,
	input logic     w_ready,
	input logic     r_ready,
	input logic     b_ready,
	input logic     rf_wen
);

	int fail_count = 0;

	// --------------------------------------------------
	// hold until ready
	// --------------------------------------------------

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar.valid && !ar_ready |=> ar.valid && $stable(ar)) else begin
		$error("AR valid or payload moved before ready");
		fail_count++;
	end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw.valid && !aw_ready |=> aw.valid && $stable(aw)) else begin
		$error("AW valid or payload moved before ready");
		fail_count++;
	end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		w.valid && !w_ready |=> w.valid && $stable(w)) else begin
		$error("W valid or payload moved before ready");
		fail_count++;
	end

	// single beat bursts
	w_last: assert property (@(posedge clock) disable iff (reset)
		w.last == w.valid) else begin
		$error("W last differs from W valid");
		fail_count++;
	end

	reset_quiet: assert property (@(posedge clock)
		reset |=> !ar.valid && !aw.valid && !w.valid && !r_ready && !b_ready && !rf_wen)
		else begin
		$error("control output high right after reset");
		fail_count++;
	end

	// any open bus phase means the stage is occupied
	busy_blocks: assert property (@(posedge clock) disable iff (reset)
		(ar.valid || aw.valid || w.valid || r_ready || b_ready) |-> !req_allowin) else begin
		$error("request accepted while an access is in flight");
		fail_count++;
	end

endmodule

bind lsu lsu_props props (
	.clock       (clock),
	.reset       (reset),
	.req_allowin (req_allowin),
	.ar          (ar),
	.ar_ready    (ar_ready),
	.aw          (aw),
	.aw_ready    (aw_ready),
	.w           (w),
	.w_ready     (w_ready),
	.r_ready     (r_ready),
	.b_ready     (b_ready),
	.rf_wen      (rf_wen)
);

// ==== verification/lsu_tb.sv ====
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();

	localparam int MEM_BYTES  = 512;
	localparam int WAIT_LIMIT = 200;

	logic     clock     = 1'b0;
	logic     reset     = 1'b1;
	logic     req_valid = 1'b0;
	mem_req_t req       = '0;
	logic     ar_ready  = 1'b0;
	logic     aw_ready  = 1'b0;
	logic     w_ready   = 1'b0;
	r_chan_t  r         = '0;
	b_chan_t  b         = '0;
	logic     req_allowin;
	ar_chan_t ar;
	ar_chan_t aw;
	w_chan_t  w;
	logic     r_ready;
	logic     b_ready;
	logic     rf_wen;
	reg_idx_t rf_waddr;
	word_t    rf_wdata;

	integer seed = 72159;
	integer bus_seed;
	int     errors = 0;

	// beat memory seen by the bus, byte model for predictions
	beat_t      mem [0:MEM_BYTES/8-1];
	logic [7:0] model [0:MEM_BYTES-1];

	// slave bookkeeping for the one open read and write
	logic    rd_pend;
	addr_t   rd_addr;
	axi_id_t rd_id;
	int      rd_delay;
	logic    rd_stray;
	logic    wr_pend;
	addr_t   wr_addr;
	axi_id_t wr_id;
	int      wr_delay;
	logic    wr_stray;

	// handshakes seen during the current operation
	addr_t    ar_log [$];
	addr_t    aw_log [$];
	strb_t    strb_log [$];
	beat_t    data_log [$];
	int       wen_count;
	word_t    wen_data;
	reg_idx_t wen_addr;

	// id of the previous address handshake on each channel
	axi_id_t  ar_id_prev;
	axi_id_t  aw_id_prev;
	logic     ar_id_seen = 1'b0;
	logic     aw_id_seen = 1'b0;

	mem_op_e load_ops [4]  = '{OP_LB, OP_LBU, OP_LH, OP_LHU};
	mem_op_e store_ops [3] = '{OP_SB, OP_SH, OP_SW};
	mem_op_e all_ops [8]   = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};

	always #5 clock = ~clock;

	lsu dut (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req         (req),
		.req_allowin (req_allowin),
		.ar          (ar),
		.ar_ready    (ar_ready),
		.r           (r),
		.r_ready     (r_ready),
		.aw          (aw),
		.aw_ready    (aw_ready),
		.w           (w),
		.w_ready     (w_ready),
		.b           (b),
		.b_ready     (b_ready),
		.rf_wen      (rf_wen),
		.rf_waddr    (rf_waddr),
		.rf_wdata    (rf_wdata)
	);

	function automatic logic [7:0] fill_byte(input int a);
		return 8'((a * 13) ^ (a >> 4) ^ 8'h5a);
	endfunction

	function automatic int access_size(input mem_op_e op);
		case (op)
			OP_LW, OP_SW: return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default: return 1;
		endcase
	endfunction

	// little endian gather, then extension by opcode
	function automatic word_t expect_load(input mem_op_e op, input int a);
		word_t v;
		v = '0;
		for (int j = 0; j < access_size(op); j++) begin
			v[8*j +: 8] = model[a + j];
		end
		case (op)
			OP_LB: v = {{24{v[7]}}, v[7:0]};
			OP_LH: v = {{16{v[15]}}, v[15:0]};
			default: v = v;
		endcase
		return v;
	endfunction

	function automatic beat_t strobe_mask(input strb_t s);
		beat_t m;
		for (int k = 0; k < 8; k++) begin
			m[8*k +: 8] = {8{s[k]}};
		end
		return m;
	endfunction

	initial begin
		bus_seed = $random(seed);
		for (int i = 0; i < MEM_BYTES; i++) begin
			model[i] = fill_byte(i);
		end
	end

	// --------------------------------------------------
	// bus slave with random stalls and stray ids
	// --------------------------------------------------

	always @(posedge clock) begin
		if (reset) begin
			ar_ready <= 1'b0;
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			r        <= '0;
			b        <= '0;
			rd_pend  <= 1'b0;
			wr_pend  <= 1'b0;
			for (int i = 0; i < MEM_BYTES; i++) begin
				mem[i/8][8*(i%8) +: 8] <= fill_byte(i);
			end
		end else begin
			ar_ready <= ($random(bus_seed) & 3) != 0;
			aw_ready <= ($random(bus_seed) & 3) != 0;
			w_ready  <= ($random(bus_seed) & 1) != 0;
			if (ar.valid && ar_ready) begin
				rd_pend  <= 1'b1;
				rd_addr  <= ar.addr;
				rd_id    <= ar.id;
				rd_delay <= $random(bus_seed) & 3;
				rd_stray <= ($random(bus_seed) & 3) == 0;
			end
			if (r.valid && r_ready) begin
				r.valid <= 1'b0;
			end else if (rd_pend && !r.valid) begin
				if (rd_delay > 0) begin
					rd_delay <= rd_delay - 1;
				end else if (rd_stray) begin
					// wrong id with garbage data goes out first
					r <= '{1'b1, ~mem[rd_addr[8:3]], `LSU_RESP_OKAY, 1'b1, rd_id + axi_id_t'(1)};
					rd_stray <= 1'b0;
				end else begin
					r       <= '{1'b1, mem[rd_addr[8:3]], `LSU_RESP_OKAY, 1'b1, rd_id};
					rd_pend <= 1'b0;
				end
			end
			if (aw.valid && aw_ready) begin
				wr_addr <= aw.addr;
				wr_id   <= aw.id;
			end
			if (w.valid && w_ready) begin
				for (int k = 0; k < 8; k++) begin
					if (w.strb[k]) begin
						mem[wr_addr[8:3]][8*k +: 8] <= w.data[8*k +: 8];
					end
				end
				wr_pend  <= 1'b1;
				wr_delay <= $random(bus_seed) & 3;
				wr_stray <= ($random(bus_seed) & 3) == 0;
			end
			if (b.valid && b_ready) begin
				b.valid <= 1'b0;
			end else if (wr_pend && !b.valid) begin
				if (wr_delay > 0) begin
					wr_delay <= wr_delay - 1;
				end else if (wr_stray) begin
					b        <= '{1'b1, `LSU_RESP_OKAY, wr_id + axi_id_t'(1)};
					wr_stray <= 1'b0;
				end else begin
					b       <= '{1'b1, `LSU_RESP_OKAY, wr_id};
					wr_pend <= 1'b0;
				end
			end
		end
	end

	// handshake monitor
	always @(posedge clock) begin
		if (!reset) begin
			if (ar.valid && ar_ready) begin
				ar_log.push_back(ar.addr);
				// every transfer is 4 bytes wide
				check_value("ar.size", ar.size, 3'b010);
				if (ar_id_seen) begin
					check_value("ar.id", ar.id, axi_id_t'(ar_id_prev + 1));
				end
				ar_id_prev = ar.id;
				ar_id_seen = 1'b1;
			end
			if (aw.valid && aw_ready) begin
				aw_log.push_back(aw.addr);
				check_value("aw.size", aw.size, 3'b010);
				if (aw_id_seen) begin
					check_value("aw.id", aw.id, axi_id_t'(aw_id_prev + 1));
				end
				aw_id_prev = aw.id;
				aw_id_seen = 1'b1;
			end
			if (w.valid && w_ready) begin
				strb_log.push_back(w.strb);
				data_log.push_back(w.data);
			end
			if (rf_wen) begin
				wen_count++;
				wen_data = rf_wdata;
				wen_addr = rf_waddr;
			end
		end
	end

	// --------------------------------------------------
	// checks and operations
	// --------------------------------------------------

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_allowin(input string what);
		int   cyc;
		logic seen;
		cyc = 0;
		seen = 1'b0;
		while (!seen && cyc < WAIT_LIMIT) begin
			@(posedge clock);
			cyc++;
			seen = req_allowin;
		end
		if (!seen) begin
			$display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic run_op(input mem_op_e op, input int a, input word_t data, input reg_idx_t rd);
		int    size;
		int    passes;
		int    ba;
		logic  is_load;
		strb_t exp_strb;
		beat_t exp_lanes;
		size = access_size(op);
		passes = ((a % 4) + size > 4) ? 2 : 1;
		is_load = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
		ar_log.delete();
		aw_log.delete();
		strb_log.delete();
		data_log.delete();
		wen_count = 0;
		req_valid <= 1'b1;
		req       <= '{op, addr_t'(a), data, rd};
		wait_allowin("request acceptance");
		req_valid <= 1'b0;
		wait_allowin("operation completion");
		// one more edge so the monitor has logged the completion cycle
		@(posedge clock);
		if (is_load) begin
			check_value("ar handshakes", ar_log.size(), passes);
			check_value("aw handshakes", aw_log.size(), 0);
			for (int p = 0; p < passes && p < ar_log.size(); p++) begin
				check_value("ar.addr", ar_log[p], (a & ~3) + 4 * p);
			end
			check_value("rf_wen pulses", wen_count, 1);
			check_value("rf_waddr", wen_addr, rd);
			check_value("rf_wdata", wen_data, expect_load(op, a));
		end else begin
			check_value("aw handshakes", aw_log.size(), passes);
			check_value("w handshakes", strb_log.size(), passes);
			check_value("ar handshakes", ar_log.size(), 0);
			check_value("rf_wen pulses", wen_count, 0);
			for (int p = 0; p < passes && p < strb_log.size(); p++) begin
				exp_strb = '0;
				exp_lanes = '0;
				for (int j = 0; j < size; j++) begin
					ba = a + j;
					if ((ba / 4) == (a / 4) + p) begin
						exp_strb[ba % 8] = 1'b1;
						exp_lanes[8*(ba % 8) +: 8] = data[8*j +: 8];
					end
				end
				check_value("aw.addr", aw_log[p], (a & ~3) + 4 * p);
				check_value("w.strb", strb_log[p], exp_strb);
				check_value("w.data lanes", data_log[p] & strobe_mask(exp_strb), exp_lanes);
			end
			for (int j = 0; j < size; j++) begin
				model[a + j] = data[8*j +: 8];
			end
			// neighbours must keep their old contents
			for (int i = 0; i < MEM_BYTES; i++) begin
				check_value($sformatf("mem byte %0d", i), mem[i/8][8*(i%8) +: 8], model[i]);
			end
		end
	endtask

	task automatic report_test(input string name, input int first_err);
		$display("%-28s %s, %0d errors", name,
			(errors == first_err) ? "pass" : "fail", errors - first_err);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		int      first_err;
		mem_op_e op;
		int      a;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		first_err = errors;
		check_value("ar.valid", ar.valid, 0);
		check_value("aw.valid", aw.valid, 0);
		check_value("w.valid", w.valid, 0);
		check_value("r_ready", r_ready, 0);
		check_value("b_ready", b_ready, 0);
		check_value("rf_wen", rf_wen, 0);
		run_op(OP_SW, 'h40, 32'hc0de_8a51, 5'd0);
		run_op(OP_LW, 'h40, '0, 5'd9);
		report_test("reset and aligned word", first_err);

		first_err = errors;
		for (int off = 1; off < 8; off++) begin
			if (off != 4) begin
				run_op(OP_LW, 'h60 + off, '0, 5'(off));
			end
		end
		report_test("split word loads", first_err);

		first_err = errors;
		run_op(OP_SW, 'h80, 32'h807f_01ff, 5'd0);
		run_op(OP_SW, 'h84, 32'h7e80_fe01, 5'd0);
		run_op(OP_SW, 'h88, 32'h8001_7f80, 5'd0);
		for (int off = 0; off < 8; off++) begin
			for (int k = 0; k < 4; k++) begin
				run_op(load_ops[k], 'h80 + off, '0, 5'(off + k + 1));
			end
		end
		report_test("byte and half extension", first_err);

		first_err = errors;
		repeat (24) begin
			op = store_ops[($random(seed) & 32'h7fff) % 3];
			a = 'h100 + ($random(seed) & 'hf7);
			run_op(op, a, $random(seed), 5'd0);
		end
		report_test("random stores", first_err);

		first_err = errors;
		repeat (40) begin
			op = all_ops[$random(seed) & 7];
			a = $random(seed) & 'h1f7;
			run_op(op, a, $random(seed), 5'($random(seed) & 31));
		end
		report_test("mixed traffic", first_err);

		$display("summary: %0d check errors, %0d assertion failures",
			errors, dut.props.fail_count);
		if (errors == 0 && dut.props.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== lsu.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_lane_map.sv
hdl/lsu_read_engine.sv
hdl/lsu_write_engine.sv
hdl/lsu_load_merge.sv
hdl/lsu.sv
verification/lsu_props.sv
verification/lsu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = lsu_tb
FILELIST  = lsu.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
